/* verilog/kyber_param_pkg.sv */
package kyber_param_pkg;

	typedef logic [2:0] level_t;
	typedef logic [31:0] word_t;
	// wide enough for du = 11
	typedef logic [10:0] coef_t;
	// up to (4 + 1) * 256 coefficients
	typedef logic [10:0] coef_count_t;

	parameter int key_word_count = 8;

	// rejection key, least significant word leaves first
	parameter logic [255:0] reject_z =
		256'h4c71f20323f542376b995b3b1f9148a4aff672a336d78b38b026951e9f92e8cd;

	// u compression width
	function automatic logic [3:0] du_bits(input level_t k);
		return (k == 3'd4) ? 4'd11 : 4'd10;
	endfunction

	// v compression width
	function automatic logic [3:0] dv_bits(input level_t k);
		return (k == 3'd4) ? 4'd5 : 4'd4;
	endfunction

	// k polynomials of u plus one of v
	function automatic coef_count_t coef_total(input level_t k);
		return coef_count_t'((k + 1) * 256);
	endfunction

	function automatic coef_count_t u_count(input level_t k);
		return coef_count_t'(k * 256);
	endfunction

	function automatic logic [8:0] ct_words(input level_t k);
		case (k)
			3'd2: return 9'd192;
			3'd3: return 9'd272;
			default: return 9'd392;
		endcase
	endfunction

endpackage

/* verilog/ct_ctrl_pkg.sv */
package ct_ctrl_pkg;

	// phases of one check run, in the order they are visited
	typedef enum logic [2:0] {
		idle,
		load_ct,
		load_key,
		check,
		emit
	} phase_e;

endpackage

/* verilog/coef_if.sv */
`timescale 1ns/1ps

interface coef_if;

	kyber_param_pkg::coef_t coef;
	// one cycle strobe, always accepted
	logic valid;
	// coefficient belongs to v
	logic in_v;
	// final coefficient of the ciphertext
	logic last;

	modport source (output coef, valid, in_v, last);
	modport sink (input coef, valid, in_v, last);

endinterface

/* verilog/ct_sequencer.sv */
`timescale 1ns/1ps

module ct_sequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input kyber_param_pkg::level_t k,
	input logic ct_done,
	input logic key_done,
	input logic check_done,
	input logic emit_done,
	input logic word_req,
	output ct_ctrl_pkg::phase_e phase,
	output kyber_param_pkg::level_t level,
	output logic req_c,
	output logic ready_key
);

	ct_ctrl_pkg::phase_e phase_nxt;

	always_comb begin
		phase_nxt = phase;
		case (phase)
			ct_ctrl_pkg::idle: begin
				if (start)
					phase_nxt = ct_ctrl_pkg::load_ct;
			end
			ct_ctrl_pkg::load_ct: begin
				if (ct_done)
					phase_nxt = ct_ctrl_pkg::load_key;
			end
			ct_ctrl_pkg::load_key: begin
				if (key_done)
					phase_nxt = ct_ctrl_pkg::check;
			end
			ct_ctrl_pkg::check: begin
				if (check_done)
					phase_nxt = ct_ctrl_pkg::emit;
			end
			ct_ctrl_pkg::emit: begin
				if (emit_done)
					phase_nxt = ct_ctrl_pkg::idle;
			end
			default: phase_nxt = ct_ctrl_pkg::idle;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= ct_ctrl_pkg::idle;
			level <= 3'd2;
		end else begin
			phase <= phase_nxt;
			// security level is fixed for the whole run
			if (phase == ct_ctrl_pkg::idle && start)
				level <= k;
		end
	end

	// paced by unpack while loading c, free running for K and the re-encrypted stream
	assign req_c = (phase == ct_ctrl_pkg::load_ct) ? word_req :
		(phase == ct_ctrl_pkg::load_key || phase == ct_ctrl_pkg::check);
	assign ready_key = (phase == ct_ctrl_pkg::emit);

	// a run only begins on start
	assert property (@(posedge clk) disable iff (rst)
		phase == ct_ctrl_pkg::idle && !start |=> phase == ct_ctrl_pkg::idle);

	// unpack asks for one word at a time
	assert property (@(posedge clk) disable iff (rst)
		phase == ct_ctrl_pkg::load_ct && req_c |=> !req_c);

endmodule

/* verilog/ct_unpack.sv */
`timescale 1ns/1ps

module ct_unpack (
	input logic clk,
	input logic rst,
	input ct_ctrl_pkg::phase_e phase,
	input kyber_param_pkg::level_t level,
	input logic wen,
	input kyber_param_pkg::word_t din,
	output logic word_req,
	output logic ct_done,
	coef_if.source coefs
);

	logic [41:0] bit_buf;
	logic [41:0] keep_mask;
	logic [5:0] bit_cnt;
	logic [8:0] word_cnt;
	logic pending;
	logic need_word;
	logic [3:0] width;
	kyber_param_pkg::coef_count_t coef_idx;

	// u coefficients first, v after
	assign coefs.in_v = coef_idx >= kyber_param_pkg::u_count(level);
	assign width = coefs.in_v ? kyber_param_pkg::dv_bits(level) : kyber_param_pkg::du_bits(level);
	assign coefs.valid = (phase == ct_ctrl_pkg::load_ct) && (bit_cnt >= 6'(width));
	assign coefs.coef = bit_buf[10:0] & ((11'd1 << width) - 11'd1);
	assign coefs.last = coef_idx == kyber_param_pkg::coef_total(level) - 11'd1;
	assign ct_done = coefs.valid && coefs.last;

	assign keep_mask = (42'd1 << bit_cnt) - 42'd1;
	assign need_word = !pending && (bit_cnt < 6'(width)) &&
		(word_cnt < kyber_param_pkg::ct_words(level));

	// new word lands above the bits still held, lsb first
	always_ff @(posedge clk) begin
		if (phase == ct_ctrl_pkg::load_ct && wen)
			bit_buf <= (bit_buf & keep_mask) | ({10'd0, din} << bit_cnt);
		else if (coefs.valid)
			bit_buf <= bit_buf >> width;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bit_cnt <= '0;
			word_cnt <= '0;
			coef_idx <= '0;
			pending <= 1'b0;
			word_req <= 1'b0;
		end else begin
			word_req <= 1'b0;
			if (phase == ct_ctrl_pkg::idle) begin
				bit_cnt <= '0;
				word_cnt <= '0;
				coef_idx <= '0;
				pending <= 1'b0;
			end else if (phase == ct_ctrl_pkg::load_ct) begin
				word_req <= need_word;
				if (need_word)
					pending <= 1'b1;
				else if (wen)
					pending <= 1'b0;
				if (wen) begin
					bit_cnt <= bit_cnt + 6'd32;
					word_cnt <= word_cnt + 9'd1;
				end else if (coefs.valid) begin
					bit_cnt <= bit_cnt - 6'(width);
					coef_idx <= coef_idx + 11'd1;
				end
			end
		end
	end

	// host writes only in the phases that take words
	assert property (@(posedge clk) disable iff (rst)
		wen |-> phase inside {ct_ctrl_pkg::load_ct, ct_ctrl_pkg::load_key, ct_ctrl_pkg::check});

	// one word per req_c pulse
	assert property (@(posedge clk) disable iff (rst)
		phase == ct_ctrl_pkg::load_ct && wen |-> pending);

	assert property (@(posedge clk) disable iff (rst) bit_cnt <= 6'd42);

endmodule

/* verilog/ct_compare.sv */
`timescale 1ns/1ps

module ct_compare #(
	parameter int max_coefs = 1280
) (
	input logic clk,
	input logic rst,
	input ct_ctrl_pkg::phase_e phase,
	input kyber_param_pkg::level_t level,
	input logic wen,
	input kyber_param_pkg::word_t din,
	coef_if.sink coefs,
	output logic check_done,
	output logic equal
);

	kyber_param_pkg::coef_t coef_mem [max_coefs];
	kyber_param_pkg::coef_t host_coef;
	kyber_param_pkg::coef_t stored_coef;
	kyber_param_pkg::coef_t mask;
	kyber_param_pkg::coef_count_t idx;
	logic [3:0] width;
	logic take_word;
	logic cmp_valid;
	logic cmp_last;

	assign take_word = (phase == ct_ctrl_pkg::check) && wen;
	assign width = (idx < kyber_param_pkg::u_count(level)) ?
		kyber_param_pkg::du_bits(level) : kyber_param_pkg::dv_bits(level);
	assign mask = (11'd1 << width) - 11'd1;
	assign check_done = cmp_valid && cmp_last;

	// decoded c goes in during load_ct, read back in step with the host stream
	always_ff @(posedge clk) begin
		if (phase == ct_ctrl_pkg::load_ct && coefs.valid)
			coef_mem[idx] <= coefs.coef;
		if (take_word) begin
			stored_coef <= coef_mem[idx];
			host_coef <= din[10:0] & mask;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx <= '0;
			cmp_valid <= 1'b0;
			cmp_last <= 1'b0;
			equal <= 1'b1;
		end else begin
			cmp_valid <= take_word;
			cmp_last <= take_word && (idx == kyber_param_pkg::coef_total(level) - 11'd1);
			if (phase == ct_ctrl_pkg::idle || phase == ct_ctrl_pkg::load_key)
				idx <= '0;
			else if ((phase == ct_ctrl_pkg::load_ct && coefs.valid) || take_word)
				idx <= idx + 11'd1;
			// flag is armed for each new run and only ever cleared inside it
			if (phase == ct_ctrl_pkg::idle)
				equal <= 1'b1;
			else if (cmp_valid && host_coef != stored_coef)
				equal <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		idx <= kyber_param_pkg::coef_total(level));

	// unpack and the buffer index agree on where u ends and c ends
	assert property (@(posedge clk) disable iff (rst)
		coefs.valid |-> (coefs.in_v == (idx >= kyber_param_pkg::u_count(level))) &&
		(coefs.last == (idx == kyber_param_pkg::coef_total(level) - 11'd1)));

endmodule

/* verilog/key_select.sv */
`timescale 1ns/1ps

module key_select (
	input logic clk,
	input logic rst,
	input ct_ctrl_pkg::phase_e phase,
	input logic wen,
	input kyber_param_pkg::word_t din,
	input logic equal,
	input logic req_key,
	output logic key_done,
	output logic emit_done,
	output logic valid,
	output kyber_param_pkg::word_t dout
);

	logic [255:0] key;
	logic [255:0] out_key;
	logic [3:0] word_cnt;
	logic take_key;
	logic send_word;

	assign take_key = (phase == ct_ctrl_pkg::load_key) && wen &&
		(word_cnt < 4'(kyber_param_pkg::key_word_count));
	assign send_word = (phase == ct_ctrl_pkg::emit) && req_key &&
		(word_cnt < 4'(kyber_param_pkg::key_word_count));
	assign key_done = (phase == ct_ctrl_pkg::load_key) &&
		(word_cnt == 4'(kyber_param_pkg::key_word_count));
	// the eighth word is on dout now
	assign emit_done = valid && (word_cnt == 4'(kyber_param_pkg::key_word_count));

	// implicit rejection when any coefficient differed
	assign out_key = equal ? key : kyber_param_pkg::reject_z;

	always_ff @(posedge clk) begin
		if (take_key)
			key <= {din, key[255:32]};
		if (send_word)
			dout <= out_key[word_cnt[2:0] * 32 +: 32];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt <= '0;
			valid <= 1'b0;
		end else begin
			valid <= send_word;
			if (phase == ct_ctrl_pkg::idle || phase == ct_ctrl_pkg::check)
				word_cnt <= '0;
			else if (take_key || send_word)
				word_cnt <= word_cnt + 4'd1;
		end
	end

endmodule

/* verilog/kyber_ct_check.sv */
`timescale 1ns/1ps

module kyber_ct_check #(
	parameter int max_coefs = 1280
) (
	input logic clk,
	input logic rst,
	input logic start,
	input kyber_param_pkg::level_t k,
	input logic wen,
	input kyber_param_pkg::word_t din,
	output logic req_c,
	input logic req_key,
	output logic ready_key,
	output logic valid,
	output kyber_param_pkg::word_t dout,
	output logic [2:0] state
);

	ct_ctrl_pkg::phase_e phase;
	kyber_param_pkg::level_t level;
	logic word_req;
	logic ct_done;
	logic key_done;
	logic check_done;
	logic emit_done;
	logic equal;

	coef_if coefs ();

	ct_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.start(start),
		.k(k),
		.ct_done(ct_done),
		.key_done(key_done),
		.check_done(check_done),
		.emit_done(emit_done),
		.word_req(word_req),
		.phase(phase),
		.level(level),
		.req_c(req_c),
		.ready_key(ready_key)
	);

	ct_unpack u_unpack (
		.clk(clk),
		.rst(rst),
		.phase(phase),
		.level(level),
		.wen(wen),
		.din(din),
		.word_req(word_req),
		.ct_done(ct_done),
		.coefs(coefs.source)
	);

	ct_compare #(
		.max_coefs(max_coefs)
	) u_compare (
		.clk(clk),
		.rst(rst),
		.phase(phase),
		.level(level),
		.wen(wen),
		.din(din),
		.coefs(coefs.sink),
		.check_done(check_done),
		.equal(equal)
	);

	key_select u_key (
		.clk(clk),
		.rst(rst),
		.phase(phase),
		.wen(wen),
		.din(din),
		.equal(equal),
		.req_key(req_key),
		.key_done(key_done),
		.emit_done(emit_done),
		.valid(valid),
		.dout(dout)
	);

	assign state = phase;

endmodule

/* bench/tb_kyber_ct_check.sv */
`timescale 1ns/1ps

module tb_kyber_ct_check;

	localparam int clk_period = 40;
	localparam int max_words = 392;
	localparam int max_coefs = 1280;
	localparam int max_tests = 16;
	localparam int key_words = 8;

	logic clk;
	logic rst;
	logic start;
	kyber_param_pkg::level_t k;
	logic wen;
	kyber_param_pkg::word_t din;
	logic req_c;
	logic req_key;
	logic ready_key;
	logic valid;
	kyber_param_pkg::word_t dout;
	logic [2:0] state;

	int seed;
	longint timeout_ns;
	int test_count;
	int req_pulses;
	int valid_count;

	string test_name [max_tests];
	int test_k [max_tests];
	logic [31:0] test_mismatch [max_tests];
	logic test_accept [max_tests];

	kyber_param_pkg::word_t ct_word [max_words];
	kyber_param_pkg::word_t key_word [key_words];
	kyber_param_pkg::word_t expect_out [key_words];
	logic [10:0] ref_coef [max_coefs];

	kyber_ct_check #(
		.max_coefs(max_coefs)
	) DUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.k(k),
		.wen(wen),
		.din(din),
		.req_c(req_c),
		.req_key(req_key),
		.ready_key(ready_key),
		.valid(valid),
		.dout(dout),
		.state(state)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	// req_c pulses and valid strobes, sampled mid cycle, cleared on start
	always @(negedge clk) begin
		// key and re-encrypted words are taken freely
		if (state == 3'(ct_ctrl_pkg::load_key) || state == 3'(ct_ctrl_pkg::check))
			check_flag("req_c held while words are taken", 1'b1, req_c);
		if (start) begin
			req_pulses <= 0;
			valid_count <= 0;
		end else begin
			if (state == 3'(ct_ctrl_pkg::load_ct) && req_c)
				req_pulses <= req_pulses + 1;
			if (valid)
				valid_count <= valid_count + 1;
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// armed once the test lengths are known
	initial begin
		wait (timeout_ns > 0);
		#(timeout_ns);
		abort_run("timeout: the DUT stopped answering before the tests finished");
	end

	task automatic check_word(input string name, input kyber_param_pkg::word_t expected,
		input kyber_param_pkg::word_t actual);
		if (actual !== expected)
			abort_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_phase(input string name, input ct_ctrl_pkg::phase_e expected,
		input ct_ctrl_pkg::phase_e actual);
		if (actual !== expected)
			abort_run($sformatf("error %s: expected %s, actual %s", name, expected.name(),
				actual.name()));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("error %s: expected %b, actual %b", name, expected, actual));
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
			abort_run($sformatf("error %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	// du for the k u polynomials, dv for v; the wider pair only at k = 4
	function automatic int coef_width(input int level, input int idx);
		if (idx < level * 256)
			return (level == 4) ? 11 : 10;
		return (level == 4) ? 5 : 4;
	endfunction

	function automatic int ciphertext_words(input int level);
		int bits;
		bits = 0;
		for (int i = 0; i < (level + 1) * 256; i++)
			bits += coef_width(level, i);
		return bits / 32;
	endfunction

	// lsb first bit stream across the ciphertext words
	function automatic logic [10:0] coef_from_stream(input int pos, input int width);
		logic [10:0] value;
		value = '0;
		for (int b = 0; b < width; b++)
			value[b] = ct_word[(pos + b) / 32][(pos + b) % 32];
		return value;
	endfunction

	task automatic read_golden();
		int fd;
		int n;
		int level;
		logic [31:0] mismatch;
		string tok;
		string rest;
		string verdict;
		fd = $fopen("bench/ct_check_golden.txt", "r");
		if (fd == 0)
			abort_run("cannot open bench/ct_check_golden.txt");
		test_count = 0;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok.getc(0) == "#") begin
				n = $fgets(rest, fd);
			end else begin
				n = $fscanf(fd, "%d %h %s", level, mismatch, verdict);
				if (n != 3 || test_count == max_tests || level < 2 || level > 4)
					abort_run({"golden file line for test ", tok, " cannot be read"});
				if (verdict != "accept" && verdict != "reject")
					abort_run({"golden file gives an unknown verdict for test ", tok});
				test_name[test_count] = tok;
				test_k[test_count] = level;
				test_mismatch[test_count] = mismatch;
				test_accept[test_count] = (verdict == "accept");
				test_count++;
			end
		end
		$fclose(fd);
		if (test_count == 0)
			abort_run("golden file holds no tests");
	endtask

	task automatic make_test_data(input int t);
		int level;
		int pos;
		int width;
		int flip_idx;
		level = test_k[t];
		pos = 0;
		for (int i = 0; i < ciphertext_words(level); i++)
			ct_word[i] = $random(seed);
		for (int i = 0; i < key_words; i++)
			key_word[i] = $random(seed);
		for (int i = 0; i < (level + 1) * 256; i++) begin
			width = coef_width(level, i);
			ref_coef[i] = coef_from_stream(pos, width);
			pos += width;
		end
		if (test_mismatch[t] != 32'hffffffff) begin
			flip_idx = int'(test_mismatch[t]);
			ref_coef[flip_idx] = ref_coef[flip_idx] ^ 11'd1;
		end
		for (int i = 0; i < key_words; i++)
			expect_out[i] = test_accept[t] ? key_word[i] : kyber_param_pkg::reject_z[i * 32 +: 32];
	endtask

	task automatic wait_phase(input ct_ctrl_pkg::phase_e target);
		@(negedge clk);
		while (state != target)
			@(negedge clk);
	endtask

	// host answers each req_c pulse with one word after a random wait
	task automatic send_ciphertext(input int words);
		int gap;
		for (int i = 0; i < words; i++) begin
			@(negedge clk);
			while (!req_c)
				@(negedge clk);
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) @(posedge clk);
			@(posedge clk);
			wen <= 1'b1;
			din <= ct_word[i];
			@(posedge clk);
			wen <= 1'b0;
		end
	endtask

	// key words and re-encrypted coefficients share this path
	task automatic write_word(input kyber_param_pkg::word_t data);
		int gap;
		gap = $unsigned($random(seed)) % 3;
		repeat (gap) begin
			@(posedge clk);
			wen <= 1'b0;
		end
		@(posedge clk);
		wen <= 1'b1;
		din <= data;
	endtask

	task automatic send_reencrypted(input int level);
		kyber_param_pkg::word_t noise;
		kyber_param_pkg::word_t mask;
		for (int i = 0; i < (level + 1) * 256; i++) begin
			// junk above the coefficient width must be ignored
			noise = $random(seed);
			mask = (32'd1 << coef_width(level, i)) - 32'd1;
			write_word((noise & ~mask) | 32'(ref_coef[i]));
		end
		@(posedge clk);
		wen <= 1'b0;
	endtask

	task automatic collect_key(input string name);
		int issued;
		int got;
		logic req_seen;
		issued = 0;
		got = 0;
		req_seen = 1'b0;
		fork
			begin
				while (issued < key_words) begin
					@(posedge clk);
					if ($unsigned($random(seed)) % 3 == 0) begin
						req_key <= 1'b0;
					end else begin
						req_key <= 1'b1;
						issued++;
					end
				end
				@(posedge clk);
				req_key <= 1'b0;
			end
			begin
				while (got < key_words) begin
					@(negedge clk);
					// a strobe follows each accepted request and nothing else
					check_flag($sformatf("%s valid after request", name), req_seen, valid);
					req_seen = req_key && ready_key;
					if (valid) begin
						check_word($sformatf("%s word %0d", name, got), expect_out[got], dout);
						got++;
					end
				end
			end
		join
	endtask

	task automatic run_test(input int t);
		int level;
		level = test_k[t];
		make_test_data(t);
		@(posedge clk);
		start <= 1'b1;
		k <= 3'(level);
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_phase({test_name[t], " after start"}, ct_ctrl_pkg::load_ct,
			ct_ctrl_pkg::phase_e'(state));
		send_ciphertext(ciphertext_words(level));
		wait_phase(ct_ctrl_pkg::load_key);
		check_count({test_name[t], " req_c pulses"}, ciphertext_words(level), req_pulses);
		for (int i = 0; i < key_words; i++)
			write_word(key_word[i]);
		@(posedge clk);
		wen <= 1'b0;
		wait_phase(ct_ctrl_pkg::check);
		send_reencrypted(level);
		wait_phase(ct_ctrl_pkg::emit);
		check_flag({test_name[t], " ready_key in emit"}, 1'b1, ready_key);
		collect_key(test_name[t]);
		@(negedge clk);
		check_phase({test_name[t], " after output"}, ct_ctrl_pkg::idle,
			ct_ctrl_pkg::phase_e'(state));
		check_flag({test_name[t], " ready_key after output"}, 1'b0, ready_key);
		check_count({test_name[t], " valid strobes"}, key_words, valid_count);
	endtask

	initial begin
		longint budget;
		seed = 32'hf40a5449;
		timeout_ns = 0;
		rst <= 1'b1;
		start <= 1'b0;
		k <= 3'd2;
		wen <= 1'b0;
		din <= '0;
		req_key <= 1'b0;
		read_golden();
		budget = 0;
		for (int t = 0; t < test_count; t++)
			budget += ciphertext_words(test_k[t]) + (test_k[t] + 1) * 256 + key_words;
		timeout_ns = budget * 8 * clk_period + 20 * clk_period;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_phase("reset state", ct_ctrl_pkg::idle, ct_ctrl_pkg::phase_e'(state));
		check_flag("reset req_c", 1'b0, req_c);
		check_flag("reset ready_key", 1'b0, ready_key);
		check_flag("reset valid", 1'b0, valid);
		for (int t = 0; t < test_count; t++)
			run_test(t);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* sources.f */
verilog/kyber_param_pkg.sv
verilog/ct_ctrl_pkg.sv
verilog/coef_if.sv
verilog/ct_sequencer.sv
verilog/ct_unpack.sv
verilog/ct_compare.sv
verilog/key_select.sv
verilog/kyber_ct_check.sv
bench/tb_kyber_ct_check.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_kyber_ct_check -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* bench/ct_check_golden.txt */
# columns: test name, level k, mismatch coefficient index (hex), verdict
# index ffffffff means no mismatch; accept sends K, reject sends z
clean_k2 2 ffffffff accept
clean_k3 3 ffffffff accept
clean_k4 4 ffffffff accept
first_u_k2 2 0 reject
middle_k3 3 258 reject
last_v_k4 4 4ff reject
